// ==== project.f ====
rtl/mmu_pkg.sv
rtl/tlb_table.sv
rtl/addr_xlate.sv
rtl/fault_collect.sv
rtl/mmu.sv
testbench/mmu_sva.sv
testbench/mmu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mmu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mmu_tb \
    -Mdir obj_dir -o mmu_sim \
    -f project.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/mmu_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// ==== testbench/mmu_tb.sv ====
// mmu testbench
`timescale 1ns/1ns

module mmu_tb;

    localparam int N_CH  = 2;
    localparam int N_ENT = 16;

    localparam mmu_pkg::fault_code_t NONE = mmu_pkg::FAULT_NONE;
    localparam mmu_pkg::fault_code_t ADDR = mmu_pkg::FAULT_ADDR_ERR;
    localparam mmu_pkg::fault_code_t MISS = mmu_pkg::FAULT_TLB_MISS;
    localparam mmu_pkg::fault_code_t INV  = mmu_pkg::FAULT_TLB_INV;
    localparam mmu_pkg::fault_code_t MOD  = mmu_pkg::FAULT_TLB_MOD;

    typedef struct packed {
        logic [3:0]          index;
        mmu_pkg::tlb_entry_t entry;
    } write_row_t;

    typedef struct packed {
        logic [7:0]           asid;
        logic                 user;
        logic                 k0u;
        logic [31:0]          va0;
        logic                 st0;
        logic [31:0]          va1;
        logic                 st1;
        mmu_pkg::fault_code_t code;
        logic [3:0]           chan;
    } case_row_t;

    logic                           clk;
    logic                           rst;
    mmu_pkg::xlate_req_t [N_CH-1:0] req;
    mmu_pkg::mmu_resp_t  [N_CH-1:0] resp;
    logic [7:0]                     asid;
    logic                           is_user_mode;
    logic                           kseg0_uncached;
    logic [3:0]                     tlbrw_index;
    logic                           tlbrw_we;
    mmu_pkg::tlb_entry_t            tlbrw_wrdata;
    mmu_pkg::tlb_entry_t            tlbrw_rddata;
    logic [31:0]                    tlbp_entry_hi;
    logic [31:0]                    tlbp_index;
    mmu_pkg::fault_t                fault;

    // bench copy of the table contents
    mmu_pkg::tlb_entry_t  shadow [N_ENT];
    write_row_t           writes[$];
    case_row_t            cases[$];
    string                case_names[$];
    logic [31:0]          probes[$];
    integer               seed;
    // fault expected one cycle after the last step
    mmu_pkg::fault_t      exp_fault;
    string                fault_name;
    mmu_pkg::fault_code_t tab_code;
    logic [3:0]           tab_chan;

    mmu #(
        .N_CHANNELS    (N_CH),
        .N_TLB_ENTRIES (N_ENT)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #200000;
        $display("Error: simulation did not finish within its time limit");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    function automatic mmu_pkg::mmu_resp_t ref_xlate(input logic [31:0] va,
                                                     input logic [7:0] cur_asid,
                                                     input logic user, input logic k0u);
        mmu_pkg::mmu_resp_t  r;
        mmu_pkg::tlb_entry_t e;
        logic                found;
        r         = '0;
        e         = '0;
        found     = 1'b0;
        r.vaddr   = va;
        r.illegal = user && va[31];
        if (va[31:30] == 2'b10) begin
            // kseg0 and kseg1 drop the top three bits
            r.paddr    = {3'b000, va[28:0]};
            r.dirty    = 1'b1;
            r.uncached = va[29] || k0u;
        end else begin
            for (int i = 0; i < N_ENT; i++) begin
                if (!found && shadow[i].vpn2 == va[31:13] &&
                    (shadow[i].g || shadow[i].asid == cur_asid)) begin
                    found = 1'b1;
                    e     = shadow[i];
                end
            end
            r.miss     = !found;
            r.paddr    = {(va[12] ? e.pfn1 : e.pfn0), va[11:0]};
            r.inv      = found && !(va[12] ? e.v1 : e.v0);
            r.dirty    = va[12] ? e.d1 : e.d0;
            r.uncached = (va[12] ? e.c1 : e.c0) == 3'd2;
        end
        return r;
    endfunction

    // paddr and page flags carry no meaning on a miss
    function automatic mmu_pkg::mmu_resp_t visible(input mmu_pkg::mmu_resp_t r);
        mmu_pkg::mmu_resp_t v;
        v = r;
        if (r.miss) begin
            v.paddr    = '0;
            v.inv      = 1'b0;
            v.dirty    = 1'b0;
            v.uncached = 1'b0;
        end
        return v;
    endfunction

    function automatic mmu_pkg::fault_code_t lane_fault(input mmu_pkg::mmu_resp_t r,
                                                        input logic store);
        mmu_pkg::fault_code_t c;
        c = NONE;
        if (store && !r.dirty) c = MOD;
        if (r.inv) c = INV;
        if (r.miss) c = MISS;
        if (r.illegal) c = ADDR;
        return c;
    endfunction

    function automatic mmu_pkg::fault_t ref_fault(input mmu_pkg::mmu_resp_t r0,
                                                  input mmu_pkg::mmu_resp_t r1,
                                                  input logic s0, input logic s1);
        mmu_pkg::fault_t f;
        f = '0;
        if (lane_fault(r0, s0) != NONE) begin
            f = '{valid: 1'b1, channel: 4'd0, code: lane_fault(r0, s0), badvaddr: r0.vaddr};
        end else if (lane_fault(r1, s1) != NONE) begin
            f = '{valid: 1'b1, channel: 4'd1, code: lane_fault(r1, s1), badvaddr: r1.vaddr};
        end
        return f;
    endfunction

    function automatic logic [31:0] ref_probe(input logic [31:0] hi);
        logic [31:0] idx;
        idx = 32'h8000_0000;
        for (int i = 0; i < N_ENT; i++) begin
            if (idx[31] && shadow[i].vpn2 == hi[31:13] &&
                (shadow[i].g || shadow[i].asid == hi[7:0])) begin
                idx = 32'(i);
            end
        end
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (exp === act) else begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_write(input logic [3:0] idx, input logic [18:0] vpn2, input logic [7:0] a,
                             input logic g, input logic [19:0] pfn0, input logic [19:0] pfn1,
                             input logic [2:0] c0, input logic [2:0] c1, input logic [3:0] dv);
        write_row_t row;
        row.index = idx;
        row.entry = {vpn2, a, g, pfn0, pfn1, c0, c1, dv};
        writes.push_back(row);
    endtask

    task automatic add_case(input string name, input logic [7:0] a, input logic [1:0] mode,
                            input logic [31:0] va0, input logic [31:0] va1,
                            input logic [1:0] stores, input mmu_pkg::fault_code_t code,
                            input logic [3:0] chan);
        case_row_t row;
        row.asid = a;
        row.user = mode[1];
        row.k0u  = mode[0];
        row.va0  = va0;
        row.st0  = stores[0];
        row.va1  = va1;
        row.st1  = stores[1];
        row.code = code;
        row.chan = chan;
        cases.push_back(row);
        case_names.push_back(name);
    endtask

    task automatic build_tables();
        // index vpn2 asid g pfn0 pfn1 c0 c1 {d0 d1 v0 v1}
        add_write(4'd0, 19'h00010, 8'd5, 1'b0, 20'h11111, 20'h22222, 3'd3, 3'd2, 4'b1011);
        add_write(4'd1, 19'h00010, 8'd7, 1'b0, 20'h33333, 20'h44444, 3'd3, 3'd3, 4'b1111);
        add_write(4'd2, 19'h00020, 8'd9, 1'b1, 20'h55555, 20'h66666, 3'd2, 3'd3, 4'b1101);
        add_write(4'd3, 19'h60000, 8'd0, 1'b1, 20'h77777, 20'h78888, 3'd3, 3'd3, 4'b1011);
        add_write(4'd4, 19'h00030, 8'd5, 1'b0, 20'h0ABCD, 20'h0BCDE, 3'd3, 3'd3, 4'b1111);
        add_write(4'd5, 19'h00020, 8'd9, 1'b0, 20'h12345, 20'h23456, 3'd2, 3'd2, 4'b1111);
        // name asid {user k0u} va0 va1 {st1 st0} fault channel
        add_case("kseg0_cached", 8'd5, 2'b00, 32'h8012_3000, 32'h9FFF_F000, 2'b01, NONE, 4'd0);
        add_case("kseg0_uncached", 8'd5, 2'b01, 32'h8012_3000, 32'h9FFF_F000, 2'b01, NONE, 4'd0);
        add_case("kseg1", 8'd5, 2'b00, 32'hA000_4000, 32'hBFFF_E000, 2'b01, NONE, 4'd0);
        add_case("even_odd", 8'd5, 2'b00, 32'h0002_0000, 32'h0002_1000, 2'b01, NONE, 4'd0);
        add_case("asid_seven", 8'd7, 2'b00, 32'h0002_0000, 32'h0002_1000, 2'b11, NONE, 4'd0);
        add_case("asid_miss", 8'd6, 2'b00, 32'h0002_0000, 32'h8000_0000, 2'b00, MISS, 4'd0);
        add_case("global_first", 8'd9, 2'b00, 32'h0004_1000, 32'hC000_0000, 2'b10, NONE, 4'd0);
        add_case("invalid_page", 8'd3, 2'b00, 32'h0004_0000, 32'h8000_0000, 2'b00, INV, 4'd0);
        add_case("store_clean", 8'd5, 2'b00, 32'h0002_1000, 32'hA000_0000, 2'b01, MOD, 4'd0);
        add_case("user_kseg", 8'd5, 2'b10, 32'h8000_1000, 32'h0002_0000, 2'b00, ADDR, 4'd0);
        add_case("both_fault", 8'd6, 2'b00, 32'hC000_1000, 32'h0002_0000, 2'b01, MOD, 4'd0);
        add_case("lane1_only", 8'd5, 2'b00, 32'h0002_0000, 32'h0004_0000, 2'b00, INV, 4'd1);
        add_case("no_fault_user", 8'd5, 2'b10, 32'h0006_0000, 32'h0002_0000, 2'b01, NONE, 4'd0);
        add_case("user_kseg2", 8'd5, 2'b10, 32'h0006_1000, 32'hC000_0000, 2'b01, ADDR, 4'd1);
        // entry-hi is vpn2 in the top bits and asid in the low byte
        probes = '{32'h0002_0007, 32'h0002_0005, 32'h0004_0009,
                   32'h0006_0006, 32'h2468_A000, 32'h0000_0000};
    endtask

    task automatic drive_req(input logic [31:0] va0, input logic st0,
                             input logic [31:0] va1, input logic st1);
        req[0].vaddr = va0;
        req[0].store = st0;
        req[1].vaddr = va1;
        req[1].store = st1;
    endtask

    task automatic check_step(input string name, input mmu_pkg::fault_code_t code,
                              input logic [3:0] chan);
        mmu_pkg::mmu_resp_t exp_r [N_CH];
        #2;
        for (int i = 0; i < N_CH; i++) begin
            exp_r[i] = ref_xlate(req[i].vaddr, asid, is_user_mode, kseg0_uncached);
            check_value($sformatf("%s lane %0d", name, i), 128'(visible(exp_r[i])),
                        128'(visible(resp[i])));
        end
        check_value({fault_name, " fault"}, 128'(exp_fault), 128'(fault));
        check_value({fault_name, " fault code"}, 128'({tab_code, tab_chan}),
                    128'({fault.code, fault.channel}));
        exp_fault  = ref_fault(exp_r[0], exp_r[1], req[0].store, req[1].store);
        fault_name = name;
        tab_code   = code;
        tab_chan   = chan;
    endtask

    task automatic wait_fault_clear();
        int n;
        n = 0;
        while (fault.valid !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                $display("Error: fault report stayed valid after reset");
                $display("SIMULATION FAILED");
                $fatal(1, "reset timeout");
            end
        end
    endtask

    initial begin
        logic [31:0]         off0;
        logic [31:0]         off1;
        mmu_pkg::tlb_entry_t new_entry;
        seed           = 85308;
        rst            = 1'b1;
        asid           = 8'd0;
        is_user_mode   = 1'b0;
        kseg0_uncached = 1'b0;
        tlbrw_index    = 4'd0;
        tlbrw_we       = 1'b0;
        tlbrw_wrdata   = '0;
        tlbp_entry_hi  = 32'h0;
        drive_req(32'h8000_0000, 1'b0, 32'h8000_0000, 1'b0);
        foreach (shadow[i]) shadow[i] = '0;
        exp_fault  = '0;
        fault_name = "idle";
        tab_code   = NONE;
        tab_chan   = 4'd0;
        build_tables();

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_fault_clear();

        foreach (writes[k]) begin
            @(negedge clk);
            tlbrw_we     = 1'b1;
            tlbrw_index  = writes[k].index;
            tlbrw_wrdata = writes[k].entry;
            shadow[writes[k].index] = writes[k].entry;
        end
        @(negedge clk);
        tlbrw_we = 1'b0;

        foreach (writes[k]) begin
            @(negedge clk);
            tlbrw_index = writes[k].index;
            #2;
            check_value($sformatf("readback %0d", writes[k].index),
                        128'(shadow[writes[k].index]), 128'(tlbrw_rddata));
        end
        foreach (probes[k]) begin
            @(negedge clk);
            tlbp_entry_hi = probes[k];
            #2;
            check_value($sformatf("probe %h", probes[k]), 128'(ref_probe(probes[k])),
                        128'(tlbp_index));
        end

        foreach (cases[k]) begin
            off0 = $random(seed);
            off1 = $random(seed);
            @(negedge clk);
            asid           = cases[k].asid;
            is_user_mode   = cases[k].user;
            kseg0_uncached = cases[k].k0u;
            drive_req(cases[k].va0 | {20'h0, off0[11:0]}, cases[k].st0,
                      cases[k].va1 | {20'h0, off1[11:0]}, cases[k].st1);
            check_step(case_names[k], cases[k].code, cases[k].chan);
        end

        // entry 4 rewritten while both lanes look at its pair
        off0 = $random(seed);
        @(negedge clk);
        asid           = 8'd5;
        is_user_mode   = 1'b0;
        kseg0_uncached = 1'b0;
        drive_req(32'h0006_0000 | {20'h0, off0[11:0]}, 1'b1,
                  32'h0006_1000 | {20'h0, off0[11:0]}, 1'b0);
        new_entry      = shadow[4];
        new_entry.pfn0 = 20'h0F00D;
        new_entry.pfn1 = 20'h0FEED;
        new_entry.c1   = 3'd2;
        new_entry.d0   = 1'b0;
        tlbrw_index    = 4'd4;
        tlbrw_wrdata   = new_entry;
        tlbrw_we       = 1'b1;
        check_step("write_same_cycle", NONE, 4'd0);
        @(negedge clk);
        tlbrw_we  = 1'b0;
        shadow[4] = new_entry;
        check_step("write_next_cycle", MOD, 4'd0);

        @(negedge clk);
        drive_req(32'h8000_0000, 1'b0, 32'h8000_0000, 1'b0);
        check_step("drain", NONE, 4'd0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== testbench/mmu_sva.sv ====
// fault report and probe checks
`timescale 1ns/1ns

module mmu_sva #(
    parameter N_CHANNELS = 2
) (
    input logic            clk,
    input logic            rst,
    input mmu_pkg::fault_t fault,
    input logic [31:0]     tlbp_index
);

    reset_clears_fault: assert property (@(posedge clk) rst |=> !fault.valid)
        else $error("fault report valid in the cycle after reset");

    valid_has_code: assert property (@(posedge clk) disable iff (rst)
        fault.valid |-> fault.code != mmu_pkg::FAULT_NONE)
        else $error("valid fault report carries no fault code");

    channel_in_range: assert property (@(posedge clk) disable iff (rst)
        fault.valid |-> 32'(fault.channel) < N_CHANNELS)
        else $error("fault report names a channel that does not exist");

    // no-match flag excludes any index bits
    probe_flag_alone: assert property (@(posedge clk) disable iff (rst)
        tlbp_index[31] |-> tlbp_index[30:0] == '0)
        else $error("probe result has the no-match flag and an index together");

endmodule

// fault register from u_fault and probe result from u_table
bind mmu mmu_sva #(
    .N_CHANNELS (N_CHANNELS)
) u_sva (
    .clk        (clk),
    .rst        (rst),
    .fault      (fault),
    .tlbp_index (tlbp_index)
);

// ==== rtl/mmu.sv ====
// memory map unit top
`timescale 1ns/1ns

module mmu #(
    parameter N_CHANNELS    = 2,
    parameter N_TLB_ENTRIES = 16
) (
    input  logic                                    clk,
    input  logic                                    rst,
    // translation lanes
    input  mmu_pkg::xlate_req_t [N_CHANNELS-1:0]    req,
    output mmu_pkg::mmu_resp_t  [N_CHANNELS-1:0]    resp,
    // from cp0
    input  logic [7:0]                              asid,
    input  logic                                    is_user_mode,
    input  logic                                    kseg0_uncached,
    // TLBR / TLBWI
    input  logic [$clog2(N_TLB_ENTRIES)-1:0]        tlbrw_index,
    input  logic                                    tlbrw_we,
    input  mmu_pkg::tlb_entry_t                     tlbrw_wrdata,
    output mmu_pkg::tlb_entry_t                     tlbrw_rddata,
    // TLBP
    input  logic [31:0]                             tlbp_entry_hi,
    output logic [31:0]                             tlbp_index,
    // exception report
    output mmu_pkg::fault_t                         fault
);

    mmu_pkg::tlb_entry_t [N_TLB_ENTRIES-1:0] entries;

    tlb_table #(
        .N_TLB_ENTRIES (N_TLB_ENTRIES)
    ) u_table (
        .clk           (clk),
        .rst           (rst),
        .tlbrw_index   (tlbrw_index),
        .tlbrw_we      (tlbrw_we),
        .tlbrw_wrdata  (tlbrw_wrdata),
        .tlbrw_rddata  (tlbrw_rddata),
        .tlbp_entry_hi (tlbp_entry_hi),
        .tlbp_index    (tlbp_index),
        .entries       (entries)
    );

    for (genvar i = 0; i < N_CHANNELS; i++) begin : gen_lane
        addr_xlate #(
            .N_TLB_ENTRIES (N_TLB_ENTRIES)
        ) u_xlate (
            .req            (req[i]),
            .entries        (entries),
            .asid           (asid),
            .is_user_mode   (is_user_mode),
            .kseg0_uncached (kseg0_uncached),
            .resp           (resp[i])
        );
    end

    fault_collect #(
        .N_CHANNELS (N_CHANNELS)
    ) u_fault (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .resp  (resp),
        .fault (fault)
    );

endmodule

// ==== rtl/fault_collect.sv ====
// lane fault collector
`timescale 1ns/1ns

module fault_collect #(
    parameter N_CHANNELS = 2
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  mmu_pkg::xlate_req_t [N_CHANNELS-1:0]    req,
    input  mmu_pkg::mmu_resp_t  [N_CHANNELS-1:0]    resp,
    output mmu_pkg::fault_t                         fault
);

    mmu_pkg::fault_code_t lane_code [N_CHANNELS];
    mmu_pkg::fault_t      fault_d;

    // highest priority first
    function automatic mmu_pkg::fault_code_t classify(input mmu_pkg::mmu_resp_t r,
                                                      input logic store);
        if (r.illegal) return mmu_pkg::FAULT_ADDR_ERR;
        if (r.miss) return mmu_pkg::FAULT_TLB_MISS;
        if (r.inv) return mmu_pkg::FAULT_TLB_INV;
        if (store && !r.dirty) return mmu_pkg::FAULT_TLB_MOD;
        return mmu_pkg::FAULT_NONE;
    endfunction

    always_comb begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            lane_code[i] = classify(resp[i], req[i].store);
        end
    end

    // lowest-numbered faulting lane is reported
    always_comb begin
        fault_d = '0;
        for (int i = N_CHANNELS - 1; i >= 0; i--) begin
            if (lane_code[i] != mmu_pkg::FAULT_NONE) begin
                fault_d.valid    = 1'b1;
                fault_d.channel  = 4'(i);
                fault_d.code     = lane_code[i];
                fault_d.badvaddr = req[i].vaddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fault <= '0;
        end else begin
            fault <= fault_d;
        end
    end

endmodule

// ==== rtl/addr_xlate.sv ====
// single translation lane
`timescale 1ns/1ns

module addr_xlate #(
    parameter N_TLB_ENTRIES = 16
) (
    input  mmu_pkg::xlate_req_t                    req,
    input  mmu_pkg::tlb_entry_t [N_TLB_ENTRIES-1:0] entries,
    input  logic [7:0]                             asid,
    input  logic                                   is_user_mode,
    input  logic                                   kseg0_uncached,
    output mmu_pkg::mmu_resp_t                     resp
);

    logic [2:0]           seg;
    logic                 mapped;
    logic                 seg_uncached;

    logic                 hit;
    mmu_pkg::tlb_entry_t  hit_entry;

    logic [19:0]          sel_pfn;
    logic [2:0]           sel_c;
    logic                 sel_d;
    logic                 sel_v;

    assign seg = req.vaddr.by_seg.seg;

    // kseg0 and kseg1 bypass the tlb, everything else is mapped
    assign mapped = (seg != mmu_pkg::SEG_KSEG0) && (seg != mmu_pkg::SEG_KSEG1);

    assign seg_uncached = (seg == mmu_pkg::SEG_KSEG1) ||
                          ((seg == mmu_pkg::SEG_KSEG0) && kseg0_uncached);

    // associative match, lowest index has priority
    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = N_TLB_ENTRIES - 1; i >= 0; i--) begin
            if ((entries[i].vpn2 == req.vaddr.by_page.vpn2) &&
                (entries[i].g || entries[i].asid == asid)) begin
                hit       = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

    // even or odd half of the pair
    always_comb begin
        if (req.vaddr.by_page.odd) begin
            sel_pfn = hit_entry.pfn1;
            sel_c   = hit_entry.c1;
            sel_d   = hit_entry.d1;
            sel_v   = hit_entry.v1;
        end else begin
            sel_pfn = hit_entry.pfn0;
            sel_c   = hit_entry.c0;
            sel_d   = hit_entry.d0;
            sel_v   = hit_entry.v0;
        end
    end

    always_comb begin
        resp         = '0;
        resp.vaddr   = req.vaddr;
        resp.illegal = is_user_mode & seg[2];
        if (mapped) begin
            resp.paddr    = {sel_pfn, req.vaddr.by_page.page_offset};
            resp.miss     = ~hit;
            resp.inv      = hit & ~sel_v;
            resp.dirty    = sel_d;
            resp.uncached = (sel_c == mmu_pkg::CACHE_UNCACHED);
        end else begin
            resp.paddr    = {3'b000, req.vaddr.by_seg.offset};
            resp.miss     = 1'b0;
            resp.inv      = 1'b0;
            // unmapped space is always writable
            resp.dirty    = 1'b1;
            resp.uncached = seg_uncached;
        end
    end

endmodule

// ==== rtl/tlb_table.sv ====
// tlb entry storage and probe
`timescale 1ns/1ns

module tlb_table #(
    parameter N_TLB_ENTRIES = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    // TLBR / TLBWI
    input  logic [$clog2(N_TLB_ENTRIES)-1:0]   tlbrw_index,
    input  logic                               tlbrw_we,
    input  mmu_pkg::tlb_entry_t                tlbrw_wrdata,
    output mmu_pkg::tlb_entry_t                tlbrw_rddata,
    // TLBP
    input  logic [31:0]                        tlbp_entry_hi,
    output logic [31:0]                        tlbp_index,
    // whole table to the lanes
    output mmu_pkg::tlb_entry_t [N_TLB_ENTRIES-1:0] entries
);

    mmu_pkg::virt_t            probe_hi;
    logic [7:0]                probe_asid;
    logic [N_TLB_ENTRIES-1:0]  probe_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            entries <= '0;
        end else if (tlbrw_we) begin
            entries[tlbrw_index] <= tlbrw_wrdata;
        end
    end

    assign tlbrw_rddata = entries[tlbrw_index];

    // entry-hi carries vpn2 in the page view and asid in its low byte
    assign probe_hi   = tlbp_entry_hi;
    assign probe_asid = tlbp_entry_hi[7:0];

    always_comb begin
        for (int i = 0; i < N_TLB_ENTRIES; i++) begin
            probe_hit[i] = (entries[i].vpn2 == probe_hi.by_page.vpn2) &&
                           (entries[i].g || entries[i].asid == probe_asid);
        end
    end

    // lowest hit wins, bit 31 flags no match
    always_comb begin
        tlbp_index = 32'h8000_0000;
        for (int i = N_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (probe_hit[i]) begin
                tlbp_index = 32'(i);
            end
        end
    end

endmodule

// ==== rtl/mmu_pkg.sv ====
// memory map unit types
package mmu_pkg;

    // fixed segment codes, vaddr[31:29]
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // cache attribute meaning uncached
    localparam logic [2:0] CACHE_UNCACHED = 3'd2;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] offset;
    } virt_seg_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] page_offset;
    } virt_page_t;

    // one virtual address, seen as segment or as page
    typedef union packed {
        virt_seg_t  by_seg;
        virt_page_t by_page;
    } virt_t;

    // joint tlb entry, one even/odd page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic [2:0]  c0;
        logic [2:0]  c1;
        logic        d0;
        logic        d1;
        logic        v0;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        virt_t vaddr;
        logic  store;
    } xlate_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        virt_t       vaddr;
        logic        miss;
        logic        inv;
        logic        illegal;
        logic        uncached;
        // writable page
        logic        dirty;
    } mmu_resp_t;

    typedef enum logic [2:0] {
        FAULT_NONE     = 3'd0,
        FAULT_ADDR_ERR = 3'd1,
        FAULT_TLB_MISS = 3'd2,
        FAULT_TLB_INV  = 3'd3,
        FAULT_TLB_MOD  = 3'd4
    } fault_code_t;

    // registered exception report
    typedef struct packed {
        logic        valid;
        logic [3:0]  channel;
        fault_code_t code;
        logic [31:0] badvaddr;
    } fault_t;

endpackage
